//--- router_defs.svh
// sizes shared by the router blocks
// the header view of a stream word assumes an 8-bit data width
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// stream word width
`define ROUTER_DATA_WIDTH 8

// number of demux outputs
`define ROUTER_NUM_PORTS 4

// route table entries, one per header destination
`define ROUTER_DEST_COUNT 16

// per-port frame counters wrap at this width
`define ROUTER_STAT_WIDTH 8

`endif

//--- route_pkg.sv
// routing types: output index, destination id and route header layout
// the header is fixed to 8 bits, dest in the upper nibble
`include "router_defs.svh"

package route_pkg;

    // output index of the demux
    typedef logic [$clog2(`ROUTER_NUM_PORTS)-1:0] port_sel_t;

    // destination field of the route header
    typedef logic [$clog2(`ROUTER_DEST_COUNT)-1:0] dest_id_t;

    typedef struct packed {
        dest_id_t   dest;
        logic [3:0] tag;
    } route_hdr_t;

endpackage

//--- stream_pkg.sv
// beat types for the byte stream
// the union gives two views of one word, payload or route header
`include "router_defs.svh"

package stream_pkg;

    // one stream word
    typedef logic [`ROUTER_DATA_WIDTH-1:0] data_t;

    // first beat of a frame is read as a header,
    // every other beat is plain payload
    typedef union packed {
        data_t                 raw;
        route_pkg::route_hdr_t hdr;
    } stream_word_u;

endpackage

//--- route_table.sv
// destination to output port table, written through a four-phase req/ack port
// lookup is combinational on whatever word is presented, table cannot be read back
`timescale 1ns/10ps
`include "router_defs.svh"

module route_table (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    cfg_req,
    input  route_pkg::dest_id_t     cfg_addr,
    input  route_pkg::port_sel_t    cfg_port,
    output logic                    cfg_ack,
    input  stream_pkg::stream_word_u word,
    output route_pkg::port_sel_t    select
);
    import route_pkg::*;

    port_sel_t entry_q [`ROUTER_DEST_COUNT];
    logic      ack_q;

    // req high and ack low marks a fresh request, written exactly once
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            // default spread: destination d goes to port d mod 4
            for (int i = 0; i < `ROUTER_DEST_COUNT; i++) begin
                entry_q[i] <= port_sel_t'(i % `ROUTER_NUM_PORTS);
            end
        end else begin
            if (cfg_req && !ack_q) begin
                entry_q[cfg_addr] <= cfg_port;
                ack_q <= 1'b1;
            end else if (!cfg_req) begin
                // release ack once the master has dropped req
                ack_q <= 1'b0;
            end
        end
    end

    assign cfg_ack = ack_q;

    // only meaningful while the word is a frame header
    assign select = entry_q[word.hdr.dest];

endmodule

//--- stream_demux.sv
// frame-aware 4-way stream demux with registered outputs and a one-beat skid
// output data, tlast and tuser are shared, only the owning port raises tvalid
`timescale 1ns/10ps
`include "router_defs.svh"

module stream_demux #(
    parameter int DATA_WIDTH = `ROUTER_DATA_WIDTH
) (
    input  logic                         clk,
    input  logic                         rst,

    input  logic [DATA_WIDTH-1:0]        s_tdata,
    input  logic                         s_tvalid,
    output logic                         s_tready,
    input  logic                         s_tlast,
    input  logic                         s_tuser,

    output logic [DATA_WIDTH-1:0]        m_tdata,
    output logic                         m_tlast,
    output logic                         m_tuser,
    output logic [`ROUTER_NUM_PORTS-1:0] m_tvalid,
    input  logic [`ROUTER_NUM_PORTS-1:0] m_tready,

    input  logic                         enable,
    input  route_pkg::port_sel_t         select
);
    import route_pkg::*;

    localparam int NUM_PORTS = `ROUTER_NUM_PORTS;

    // frame ownership
    port_sel_t sel_q;
    port_sel_t sel_d;
    logic      frame_q;
    logic      frame_d;
    logic      s_tready_q;
    logic      s_tready_d;

    // handshake seen by the output stage
    logic      int_ready_q;
    logic      int_ready_early;
    logic      in_accept;
    logic      cur_tvalid;
    logic      cur_tready;
    logic [NUM_PORTS-1:0] port_onehot;

    // output and skid registers
    logic [NUM_PORTS-1:0]  m_tvalid_q;
    logic [NUM_PORTS-1:0]  m_tvalid_d;
    logic [DATA_WIDTH-1:0] out_tdata_q;
    logic                  out_tlast_q;
    logic                  out_tuser_q;
    logic [DATA_WIDTH-1:0] skid_tdata_q;
    logic                  skid_tlast_q;
    logic                  skid_tuser_q;
    logic                  skid_valid_q;
    logic                  skid_valid_d;

    logic load_in_out;
    logic load_in_skid;
    logic load_skid_out;

    assign cur_tvalid  = m_tvalid_q[sel_q];
    assign cur_tready  = m_tready[sel_q];
    assign in_accept   = s_tvalid & s_tready_q;
    assign port_onehot = NUM_PORTS'(1) << sel_q;

    // a new frame waits for the previous owner's output to drain,
    // since the data registers are shared by all ports
    always_comb begin
        sel_d   = sel_q;
        frame_d = frame_q;
        if (frame_q) begin
            if (in_accept) begin
                frame_d = ~s_tlast;
            end
        end else if (enable && s_tvalid && !cur_tvalid) begin
            frame_d = 1'b1;
            sel_d   = select;
        end
    end

    // stay ready unless a stalled output would push a second beat into the skid
    assign int_ready_early = cur_tready | (~skid_valid_q & (~cur_tvalid | ~in_accept));
    assign s_tready_d      = int_ready_early & frame_d;

    always_comb begin
        m_tvalid_d    = m_tvalid_q;
        skid_valid_d  = skid_valid_q;
        load_in_out   = 1'b0;
        load_in_skid  = 1'b0;
        load_skid_out = 1'b0;
        if (int_ready_q) begin
            if (cur_tready || !cur_tvalid) begin
                // output free, input beat goes straight through
                m_tvalid_d  = in_accept ? port_onehot : '0;
                load_in_out = 1'b1;
            end else begin
                // output stalled, park the beat
                skid_valid_d = in_accept;
                load_in_skid = 1'b1;
            end
        end else if (cur_tready) begin
            // refill the output from the skid
            m_tvalid_d    = skid_valid_q ? port_onehot : '0;
            skid_valid_d  = 1'b0;
            load_skid_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q        <= '0;
            frame_q      <= 1'b0;
            s_tready_q   <= 1'b0;
            int_ready_q  <= 1'b0;
            m_tvalid_q   <= '0;
            skid_valid_q <= 1'b0;
        end else begin
            sel_q        <= sel_d;
            frame_q      <= frame_d;
            s_tready_q   <= s_tready_d;
            int_ready_q  <= int_ready_early;
            m_tvalid_q   <= m_tvalid_d;
            skid_valid_q <= skid_valid_d;
        end
    end

    // payload only, qualified by the valid bits above
    always_ff @(posedge clk) begin
        if (load_in_out) begin
            out_tdata_q <= s_tdata;
            out_tlast_q <= s_tlast;
            out_tuser_q <= s_tuser;
        end else if (load_skid_out) begin
            out_tdata_q <= skid_tdata_q;
            out_tlast_q <= skid_tlast_q;
            out_tuser_q <= skid_tuser_q;
        end
        if (load_in_skid) begin
            skid_tdata_q <= s_tdata;
            skid_tlast_q <= s_tlast;
            skid_tuser_q <= s_tuser;
        end
    end

    assign s_tready = s_tready_q;
    assign m_tvalid = m_tvalid_q;
    assign m_tdata  = out_tdata_q;
    assign m_tlast  = out_tlast_q;
    assign m_tuser  = out_tuser_q;

endmodule

//--- frame_stats.sv
// completed-frame counters, one per demux output
// counters wrap silently, tlast is the shared output tlast
`timescale 1ns/10ps
`include "router_defs.svh"

module frame_stats (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`ROUTER_NUM_PORTS-1:0]  m_tvalid,
    input  logic [`ROUTER_NUM_PORTS-1:0]  m_tready,
    input  logic                          m_tlast,
    output logic [`ROUTER_STAT_WIDTH-1:0] frames0,
    output logic [`ROUTER_STAT_WIDTH-1:0] frames1,
    output logic [`ROUTER_STAT_WIDTH-1:0] frames2,
    output logic [`ROUTER_STAT_WIDTH-1:0] frames3
);

    logic [`ROUTER_STAT_WIDTH-1:0] count_q [`ROUTER_NUM_PORTS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ROUTER_NUM_PORTS; i++) begin
                count_q[i] <= '0;
            end
        end else begin
            // a frame completes when its tlast beat moves
            for (int i = 0; i < `ROUTER_NUM_PORTS; i++) begin
                if (m_tvalid[i] && m_tready[i] && m_tlast) begin
                    count_q[i] <= count_q[i] + 1'b1;
                end
            end
        end
    end

    assign frames0 = count_q[0];
    assign frames1 = count_q[1];
    assign frames2 = count_q[2];
    assign frames3 = count_q[3];

endmodule

//--- frame_router_top.sv
// frame router: route table lookup on the header beat, demux, per-port frame counts
// first beat of every frame must be a route header, tuser is carried through untouched
`timescale 1ns/10ps
`include "router_defs.svh"

module frame_router_top (
    input  logic                          clk,
    input  logic                          rst,

    input  stream_pkg::data_t             s_tdata,
    input  logic                          s_tvalid,
    output logic                          s_tready,
    input  logic                          s_tlast,
    input  logic                          s_tuser,

    output stream_pkg::data_t             m0_tdata,
    output logic                          m0_tvalid,
    input  logic                          m0_tready,
    output logic                          m0_tlast,
    output logic                          m0_tuser,
    output stream_pkg::data_t             m1_tdata,
    output logic                          m1_tvalid,
    input  logic                          m1_tready,
    output logic                          m1_tlast,
    output logic                          m1_tuser,
    output stream_pkg::data_t             m2_tdata,
    output logic                          m2_tvalid,
    input  logic                          m2_tready,
    output logic                          m2_tlast,
    output logic                          m2_tuser,
    output stream_pkg::data_t             m3_tdata,
    output logic                          m3_tvalid,
    input  logic                          m3_tready,
    output logic                          m3_tlast,
    output logic                          m3_tuser,

    input  logic                          enable,

    input  logic                          cfg_req,
    input  route_pkg::dest_id_t           cfg_addr,
    input  route_pkg::port_sel_t          cfg_port,
    output logic                          cfg_ack,

    output logic [`ROUTER_STAT_WIDTH-1:0] frames0,
    output logic [`ROUTER_STAT_WIDTH-1:0] frames1,
    output logic [`ROUTER_STAT_WIDTH-1:0] frames2,
    output logic [`ROUTER_STAT_WIDTH-1:0] frames3
);
    import route_pkg::*;
    import stream_pkg::*;

    port_sel_t                    select;
    stream_word_u                 s_word;
    data_t                        m_tdata;
    logic                         m_tlast;
    logic                         m_tuser;
    logic [`ROUTER_NUM_PORTS-1:0] m_tvalid;
    logic [`ROUTER_NUM_PORTS-1:0] m_tready;

    // input word enters as payload, the table reads it as a header
    assign s_word.raw = s_tdata;

    route_table i_route_table (
        .clk      (clk),
        .rst      (rst),
        .cfg_req  (cfg_req),
        .cfg_addr (cfg_addr),
        .cfg_port (cfg_port),
        .cfg_ack  (cfg_ack),
        .word     (s_word),
        .select   (select)
    );

    stream_demux #(
        .DATA_WIDTH (`ROUTER_DATA_WIDTH)
    ) i_stream_demux (
        .clk      (clk),
        .rst      (rst),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .s_tuser  (s_tuser),
        .m_tdata  (m_tdata),
        .m_tlast  (m_tlast),
        .m_tuser  (m_tuser),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .enable   (enable),
        .select   (select)
    );

    frame_stats i_frame_stats (
        .clk      (clk),
        .rst      (rst),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast),
        .frames0  (frames0),
        .frames1  (frames1),
        .frames2  (frames2),
        .frames3  (frames3)
    );

    assign m_tready = {m3_tready, m2_tready, m1_tready, m0_tready};

    // payload fans out to every port, tvalid picks the owner
    assign m0_tdata  = m_tdata;
    assign m0_tvalid = m_tvalid[0];
    assign m0_tlast  = m_tlast;
    assign m0_tuser  = m_tuser;
    assign m1_tdata  = m_tdata;
    assign m1_tvalid = m_tvalid[1];
    assign m1_tlast  = m_tlast;
    assign m1_tuser  = m_tuser;
    assign m2_tdata  = m_tdata;
    assign m2_tvalid = m_tvalid[2];
    assign m2_tlast  = m_tlast;
    assign m2_tuser  = m_tuser;
    assign m3_tdata  = m_tdata;
    assign m3_tvalid = m_tvalid[3];
    assign m3_tlast  = m_tlast;
    assign m3_tuser  = m_tuser;

endmodule

//--- frame_router_props.sv
// output stage assertions for the demux, attached to every stream_demux instance
// valid bits are checked as one group since data, tlast and tuser are shared
`timescale 1ns/10ps
`include "router_defs.svh"

module frame_router_props #(
    parameter int DATA_WIDTH = `ROUTER_DATA_WIDTH
) (
    input logic                         clk,
    input logic                         rst,
    input logic                         s_tvalid,
    input logic                         s_tready,
    input logic [DATA_WIDTH-1:0]        m_tdata,
    input logic                         m_tlast,
    input logic                         m_tuser,
    input logic [`ROUTER_NUM_PORTS-1:0] m_tvalid,
    input logic [`ROUTER_NUM_PORTS-1:0] m_tready
);

    // a beat taken while the output is stalled fills the skid, no further beat fits
    skid_limit: assert property (@(posedge clk) disable iff (rst)
        (|(m_tvalid & ~m_tready) && s_tvalid && s_tready) |=> !s_tready)
        else $error("s_tready stayed high after a beat went into the skid register");

    // a stalled output keeps its beat untouched
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        |(m_tvalid & ~m_tready) |=> $stable(m_tvalid) && $stable(m_tdata)
                                    && $stable(m_tlast) && $stable(m_tuser))
        else $error("stalled output beat changed before it moved");

    reset_quiet: assert property (@(posedge clk) rst |=> (!s_tready && m_tvalid == '0))
        else $error("s_tready or an output valid high after reset");

endmodule

bind stream_demux frame_router_props #(
    .DATA_WIDTH (DATA_WIDTH)
) i_props (
    .clk      (clk),
    .rst      (rst),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .m_tdata  (m_tdata),
    .m_tlast  (m_tlast),
    .m_tuser  (m_tuser),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready)
);

//--- frame_router_checker.sv
// compares router outputs with per-port queues built from accepted input beats
// the table model starts from the reset spread and follows cfg writes
`timescale 1ns/10ps
`include "router_defs.svh"

module frame_router_checker (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [`ROUTER_DATA_WIDTH-1:0]                        s_tdata,
    input  logic                                                 s_tvalid,
    input  logic                                                 s_tready,
    input  logic                                                 s_tlast,
    input  logic                                                 s_tuser,
    input  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_DATA_WIDTH-1:0] m_tdata,
    input  logic [`ROUTER_NUM_PORTS-1:0]                         m_tvalid,
    input  logic [`ROUTER_NUM_PORTS-1:0]                         m_tready,
    input  logic [`ROUTER_NUM_PORTS-1:0]                         m_tlast,
    input  logic [`ROUTER_NUM_PORTS-1:0]                         m_tuser,
    input  logic                                                 enable,
    input  logic                                                 cfg_req,
    input  route_pkg::dest_id_t                                  cfg_addr,
    input  route_pkg::port_sel_t                                 cfg_port,
    input  logic                                                 cfg_ack,
    input  logic [`ROUTER_NUM_PORTS-1:0][`ROUTER_STAT_WIDTH-1:0] frames,
    input  logic                                                 final_check,
    output int                                                   errors,
    output int                                                   frames_done,
    output int                                                   pending,
    output logic                                                 checked
);
    import route_pkg::*;

    localparam int BEAT_W = `ROUTER_DATA_WIDTH + 2;

    port_sel_t                     table_model [`ROUTER_DEST_COUNT];
    // each entry is {tuser, tlast, tdata}
    logic [BEAT_W-1:0]             exp_q [`ROUTER_NUM_PORTS][$];
    logic [`ROUTER_STAT_WIDTH-1:0] exp_frames [`ROUTER_NUM_PORTS];
    int                            beat_cnt [`ROUTER_NUM_PORTS];
    int                            frame_err [`ROUTER_NUM_PORTS];
    logic                          in_frame;
    port_sel_t                     in_port;
    logic                          req_prev;
    logic                          enable_prev;

    always @(posedge clk) begin
        logic [BEAT_W-1:0] exp_beat;
        logic [BEAT_W-1:0] got_beat;
        if (rst) begin
            for (int d = 0; d < `ROUTER_DEST_COUNT; d++) begin
                table_model[d] = port_sel_t'(d % `ROUTER_NUM_PORTS);
            end
            for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
                exp_q[p].delete();
                exp_frames[p] = '0;
                beat_cnt[p]   = 0;
                frame_err[p]  = 0;
            end
            in_frame    = 1'b0;
            in_port     = '0;
            req_prev    = cfg_req;
            enable_prev = enable;
            errors      = 0;
            frames_done = 0;
            checked     = 1'b0;
        end else begin
            // four-phase port, ack is req delayed by one cycle
            if (cfg_ack !== req_prev) begin
                errors++;
                $display("Mismatch at %0t: cfg_ack %b, expected %b", $time, cfg_ack, req_prev);
            end
            // one write per rising req
            if (cfg_req && !req_prev) begin
                table_model[cfg_addr] = cfg_port;
            end
            if (!in_frame && s_tready && !enable_prev) begin
                errors++;
                $display("s_tready went high at %0t although enable was low", $time);
            end

            if (s_tvalid && s_tready) begin
                if (!in_frame) begin
                    // dest sits in the upper nibble of the header beat
                    in_port  = table_model[s_tdata[7:4]];
                    in_frame = 1'b1;
                end
                exp_q[in_port].push_back({s_tuser, s_tlast, s_tdata});
                if (s_tlast) begin
                    in_frame = 1'b0;
                    exp_frames[in_port] = exp_frames[in_port] + 1'b1;
                end
            end

            for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
                if (m_tvalid[p] && m_tready[p]) begin
                    got_beat = {m_tuser[p], m_tlast[p], m_tdata[p]};
                    if (exp_q[p].size() == 0) begin
                        errors++;
                        frame_err[p]++;
                        $display("unexpected beat %h on port %0d at %0t", got_beat, p, $time);
                    end else begin
                        exp_beat = exp_q[p].pop_front();
                        if (got_beat !== exp_beat) begin
                            errors++;
                            frame_err[p]++;
                            $display("Mismatch at %0t: port %0d beat %0d got %h, expected %h",
                                     $time, p, beat_cnt[p], got_beat, exp_beat);
                        end
                    end
                    beat_cnt[p]++;
                    if (m_tlast[p]) begin
                        $display("frame %0d on port %0d: %0d beats, %0d errors",
                                 frames_done, p, beat_cnt[p], frame_err[p]);
                        frames_done++;
                        beat_cnt[p]  = 0;
                        frame_err[p] = 0;
                    end
                end
            end

            if (final_check && !checked) begin
                for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
                    if (exp_q[p].size() != 0) begin
                        errors++;
                        $display("%0d beats never arrived on port %0d", exp_q[p].size(), p);
                    end
                    if (frames[p] !== exp_frames[p]) begin
                        errors++;
                        $display("Mismatch at %0t: frames%0d is %0d, expected %0d",
                                 $time, p, frames[p], exp_frames[p]);
                    end
                end
                checked = 1'b1;
            end

            req_prev    = cfg_req;
            enable_prev = enable;
        end
        pending = 0;
        for (int p = 0; p < `ROUTER_NUM_PORTS; p++) begin
            pending += exp_q[p].size();
        end
    end

endmodule

//--- tb_frame_router.sv
// frame router testbench with table driven frames, random sink ready and cfg writes
// frames go out one after another and a row's table write happens before its frame
`timescale 1ns/10ps
`include "router_defs.svh"

module tb_frame_router;
    import route_pkg::*;

    localparam int NUM_ROWS   = 10;
    localparam int WAIT_LIMIT = 300;

    // header, payload beats, tuser on last beat, enable gap, write enable, write addr, write port
    typedef struct packed {
        logic [7:0] hdr;
        logic [3:0] len;
        logic       last_user;
        logic [3:0] gap;
        logic       wr_en;
        logic [3:0] wr_addr;
        logic [1:0] wr_port;
    } row_t;

    row_t      rows [NUM_ROWS];
    integer    seed = 95822;
    logic      timed_out = 1'b0;
    logic      clk = 1'b0;
    logic      rst;
    logic [7:0] s_tdata;
    logic      s_tvalid;
    logic      s_tready;
    logic      s_tlast;
    logic      s_tuser;
    logic      enable;
    logic      cfg_req;
    dest_id_t  cfg_addr;
    port_sel_t cfg_port;
    logic      cfg_ack;
    logic      final_check;
    logic [31:0] rnd;
    logic [3:0] sink_ready = 4'b0;
    logic [3:0][7:0] m_tdata;
    logic [3:0] m_tvalid;
    logic [3:0] m_tlast;
    logic [3:0] m_tuser;
    logic [3:0][`ROUTER_STAT_WIDTH-1:0] frames;
    int        errors;
    int        frames_done;
    int        pending;
    logic      checked;

    always #2 clk = ~clk;

    // sinks are ready about three cycles in four
    always @(negedge clk) begin
        rnd = $random(seed);
        sink_ready = rnd[3:0] | rnd[7:4];
    end

    frame_router_top i_dut (
        .clk (clk), .rst (rst),
        .s_tdata (s_tdata), .s_tvalid (s_tvalid), .s_tready (s_tready),
        .s_tlast (s_tlast), .s_tuser (s_tuser),
        .m0_tdata (m_tdata[0]), .m0_tvalid (m_tvalid[0]), .m0_tready (sink_ready[0]),
        .m0_tlast (m_tlast[0]), .m0_tuser (m_tuser[0]),
        .m1_tdata (m_tdata[1]), .m1_tvalid (m_tvalid[1]), .m1_tready (sink_ready[1]),
        .m1_tlast (m_tlast[1]), .m1_tuser (m_tuser[1]),
        .m2_tdata (m_tdata[2]), .m2_tvalid (m_tvalid[2]), .m2_tready (sink_ready[2]),
        .m2_tlast (m_tlast[2]), .m2_tuser (m_tuser[2]),
        .m3_tdata (m_tdata[3]), .m3_tvalid (m_tvalid[3]), .m3_tready (sink_ready[3]),
        .m3_tlast (m_tlast[3]), .m3_tuser (m_tuser[3]),
        .enable (enable),
        .cfg_req (cfg_req), .cfg_addr (cfg_addr), .cfg_port (cfg_port), .cfg_ack (cfg_ack),
        .frames0 (frames[0]), .frames1 (frames[1]), .frames2 (frames[2]), .frames3 (frames[3])
    );

    frame_router_checker i_checker (
        .clk (clk), .rst (rst),
        .s_tdata (s_tdata), .s_tvalid (s_tvalid), .s_tready (s_tready),
        .s_tlast (s_tlast), .s_tuser (s_tuser),
        .m_tdata (m_tdata), .m_tvalid (m_tvalid), .m_tready (sink_ready),
        .m_tlast (m_tlast), .m_tuser (m_tuser),
        .enable (enable),
        .cfg_req (cfg_req), .cfg_addr (cfg_addr), .cfg_port (cfg_port), .cfg_ack (cfg_ack),
        .frames (frames), .final_check (final_check),
        .errors (errors), .frames_done (frames_done), .pending (pending), .checked (checked)
    );

    task automatic write_route(input dest_id_t addr, input port_sel_t port);
        int n;
        cfg_addr = addr;
        cfg_port = port;
        cfg_req  = 1'b1;
        n = 0;
        while (!cfg_ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!cfg_ack) begin
            timed_out = 1'b1;
            $display("timeout while waiting for cfg_ack to rise");
        end
        cfg_req = 1'b0;
        n = 0;
        while (cfg_ack && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (cfg_ack) begin
            timed_out = 1'b1;
            $display("timeout while waiting for cfg_ack to fall");
        end
    endtask

    // present one beat and hold it until the handshake edge has passed
    task automatic send_beat(input logic [7:0] data, input logic last, input logic user);
        int n;
        s_tdata  = data;
        s_tlast  = last;
        s_tuser  = user;
        s_tvalid = 1'b1;
        n = 0;
        while (!s_tready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!s_tready) begin
            timed_out = 1'b1;
            $display("timeout while waiting for s_tready");
        end
        @(negedge clk);
        s_tvalid = 1'b0;
    endtask

    task automatic send_frame(input row_t row, input int idx);
        logic hdr_last;
        logic hdr_user;
        hdr_last = (row.len == 0);
        hdr_user = hdr_last & row.last_user;
        if (row.gap != 0) begin
            // header waits with enable low
            enable   = 1'b0;
            s_tdata  = row.hdr;
            s_tlast  = hdr_last;
            s_tuser  = hdr_user;
            s_tvalid = 1'b1;
            repeat (row.gap) @(negedge clk);
            enable = 1'b1;
        end
        send_beat(row.hdr, hdr_last, hdr_user);
        for (int b = 1; b <= row.len && !timed_out; b++) begin
            send_beat({idx[3:0], b[3:0]}, b == row.len, (b == row.len) & row.last_user);
        end
    endtask

    initial begin
        int n;
        rst         = 1'b1;
        enable      = 1'b1;
        s_tdata     = '0;
        s_tvalid    = 1'b0;
        s_tlast     = 1'b0;
        s_tuser     = 1'b0;
        cfg_req     = 1'b0;
        cfg_addr    = '0;
        cfg_port    = '0;
        final_check = 1'b0;

        rows[0] = '{8'h03, 4'd4,  1'b1, 4'd0, 1'b0, 4'h0, 2'd0};
        rows[1] = '{8'h1a, 4'd6,  1'b0, 4'd0, 1'b0, 4'h0, 2'd0};
        rows[2] = '{8'h52, 4'd3,  1'b1, 4'd3, 1'b0, 4'h0, 2'd0};
        rows[3] = '{8'h2f, 4'd0,  1'b1, 4'd0, 1'b0, 4'h0, 2'd0};
        // dest 5 moves from port 1 to port 3
        rows[4] = '{8'h57, 4'd5,  1'b1, 4'd0, 1'b1, 4'h5, 2'd3};
        rows[5] = '{8'hb1, 4'd8,  1'b0, 4'd2, 1'b0, 4'h0, 2'd0};
        rows[6] = '{8'he4, 4'd2,  1'b1, 4'd0, 1'b1, 4'he, 2'd0};
        rows[7] = '{8'h7c, 4'd12, 1'b1, 4'd0, 1'b0, 4'h0, 2'd0};
        rows[8] = '{8'h90, 4'd1,  1'b0, 4'd4, 1'b0, 4'h0, 2'd0};
        rows[9] = '{8'h66, 4'd7,  1'b1, 4'd0, 1'b0, 4'h0, 2'd0};

        repeat (10) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
            if (rows[i].wr_en) begin
                write_route(rows[i].wr_addr, rows[i].wr_port);
            end
            if (!timed_out) begin
                send_frame(rows[i], i);
            end
        end

        n = 0;
        while (pending != 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (pending != 0) begin
            timed_out = 1'b1;
            $display("timeout while waiting for the outputs to drain");
        end

        final_check = 1'b1;
        n = 0;
        while (!checked && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!checked) begin
            timed_out = 1'b1;
            $display("timeout while waiting for the final count check");
        end
        final_check = 1'b0;

        $display("frames checked %0d, errors %0d", frames_done, errors);
        if (errors == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
route_pkg.sv
stream_pkg.sv
route_table.sv
stream_demux.sv
frame_stats.sv
frame_router_top.sv
frame_router_props.sv
frame_router_checker.sv
tb_frame_router.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the frame router testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_frame_router -f flist.f -o sim_frame_router \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_frame_router > sim.log 2>&1

grep -q "RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation did not finish, see sim.log"; exit 1; }
echo "simulation passed"
